//--- include/stats_defs.svh
`ifndef STATS_DEFS_SVH
`define STATS_DEFS_SVH

// Bus geometry
`define STATS_ADDR_WIDTH 12
`define STATS_DATA_WIDTH 32

// Register map byte offsets
`define STATS_REG_CTRL 12'h000
`define STATS_REG_OCC 12'h004
`define STATS_REG_POP 12'h008
`define STATS_REG_INTERVAL 12'h00C
`define STATS_REG_SNAP 12'h010

// Anything above this answers SLVERR
`define STATS_LAST_ADDR 12'h047

`define STATS_FIFO_DEPTH 8

`endif

//--- list.f
+incdir+include
rtl/stats_pkg.sv
rtl/axi_lite_slave.sv
rtl/stats_sampler.sv
rtl/snapshot_fifo.sv
rtl/stats_regs.sv
rtl/eth_stats_collector_axi.sv
sim/clk_gen.sv
sim/tb_eth_stats_collector_axi.sv

//--- rtl/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_defs.svh"

module axi_lite_slave (
	input wire clk,
	input wire reset,

	input wire [`STATS_ADDR_WIDTH-1:0] awaddr,
	input wire [2:0] awprot,
	input wire awvalid,
	output logic awready,

	input wire [`STATS_DATA_WIDTH-1:0] wdata,
	input wire [`STATS_DATA_WIDTH/8-1:0] wstrb,
	input wire wvalid,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,

	input wire [`STATS_ADDR_WIDTH-1:0] araddr,
	input wire [2:0] arprot,
	input wire arvalid,
	output logic arready,

	output logic [`STATS_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,

	output logic write_req,
	output logic [`STATS_ADDR_WIDTH-1:0] write_addr,
	output logic [`STATS_DATA_WIDTH-1:0] write_data,
	output logic [`STATS_DATA_WIDTH/8-1:0] write_strb,
	input wire write_ready,
	input wire stats_pkg::axi_resp_t write_resp,

	output logic read_req,
	output logic [`STATS_ADDR_WIDTH-1:0] read_addr,
	input wire read_ready,
	input wire stats_pkg::axi_resp_t read_resp,
	input wire [`STATS_DATA_WIDTH-1:0] read_value
);
	logic wr_accept;
	logic rd_accept;

	// One transaction per path until its response has been taken
	assign wr_accept = awvalid & wvalid & ~write_req & ~bvalid;
	assign rd_accept = arvalid & ~read_req & ~rvalid;

	assign awready = wr_accept;
	assign wready = wr_accept;
	assign arready = rd_accept;

	always_ff @(posedge clk) begin
		if (reset) begin
			write_req <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (wr_accept) begin
				write_req <= 1'b1;
			end
			if (write_req && write_ready) begin
				write_req <= 1'b0;
				bvalid <= 1'b1;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			read_req <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (rd_accept) begin
				read_req <= 1'b1;
			end
			if (read_req && read_ready) begin
				read_req <= 1'b0;
				rvalid <= 1'b1;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Request and response payloads
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			write_addr <= awaddr;
			write_data <= wdata;
			write_strb <= wstrb;
		end
		if (write_req && write_ready) begin
			bresp <= write_resp;
		end
		if (rd_accept) begin
			read_addr <= araddr;
		end
		if (read_req && read_ready) begin
			rdata <= read_value;
			rresp <= read_resp;
		end
	end

endmodule

`default_nettype wire

//--- rtl/eth_stats_collector_axi.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_defs.svh"

module eth_stats_collector_axi (
	input wire clk,
	input wire reset,

	input wire [`STATS_ADDR_WIDTH-1:0] awaddr,
	input wire [2:0] awprot,
	input wire awvalid,
	output logic awready,

	input wire [`STATS_DATA_WIDTH-1:0] wdata,
	input wire [`STATS_DATA_WIDTH/8-1:0] wstrb,
	input wire wvalid,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,

	input wire [`STATS_ADDR_WIDTH-1:0] araddr,
	input wire [2:0] arprot,
	input wire arvalid,
	output logic arready,

	output logic [`STATS_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,

	output logic enable,
	output logic srst,

	input wire [63:0] current_time,
	input wire [5:0] stats_id,
	input wire [63:0] tx_bytes,
	input wire [63:0] tx_good,
	input wire [63:0] tx_bad,
	input wire [63:0] rx_bytes,
	input wire [63:0] rx_good,
	input wire [63:0] rx_bad
);
	import stats_pkg::*;

	logic write_req;
	logic [`STATS_ADDR_WIDTH-1:0] write_addr;
	logic [`STATS_DATA_WIDTH-1:0] write_data;
	logic [`STATS_DATA_WIDTH/8-1:0] write_strb;
	logic write_ready;
	axi_resp_t write_resp;

	logic read_req;
	logic [`STATS_ADDR_WIDTH-1:0] read_addr;
	logic read_ready;
	axi_resp_t read_resp;
	logic [`STATS_DATA_WIDTH-1:0] read_value;

	logic hold;
	logic use_fifo;
	logic [31:0] interval;
	logic pop_req;
	logic pop_done;
	logic [15:0] occupancy;
	logic sample_valid;
	stats_snapshot_t snapshot;
	stats_snapshot_t head;

	axi_lite_slave u_axi_lite_slave (.*);

	stats_regs u_stats_regs (.*);

	stats_sampler u_stats_sampler (.*);

	// Queue only fills in FIFO mode
	snapshot_fifo u_snapshot_fifo (
		.push(sample_valid & use_fifo),
		.push_data(snapshot),
		.*
	);

endmodule

`default_nettype wire

//--- rtl/snapshot_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_defs.svh"

module snapshot_fifo #(
	parameter int DEPTH = `STATS_FIFO_DEPTH
) (
	input wire clk,
	input wire reset,
	input wire srst,

	input wire push,
	input wire stats_pkg::stats_snapshot_t push_data,

	input wire pop_req,
	output stats_pkg::stats_snapshot_t head,
	output logic pop_done,
	output logic [15:0] occupancy
);
	import stats_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	stats_snapshot_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic full;
	logic do_pop;
	logic rd_adv;

	assign full = count == (PTR_W+1)'(DEPTH);
	assign do_pop = pop_req && (count != '0);
	// A push into a full queue pushes the oldest entry out
	assign rd_adv = do_pop | (push & full);
	assign occupancy = 16'(count);

	always_ff @(posedge clk) begin
		if (reset || srst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_adv) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(rd_adv);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Head keeps its value on a pop of an empty queue
	always_ff @(posedge clk) begin
		if (reset || srst) begin
			head <= '0;
		end else if (do_pop) begin
			head <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pop_done <= 1'b0;
		end else begin
			pop_done <= pop_req;
		end
	end

endmodule

`default_nettype wire

//--- rtl/stats_pkg.sv
`default_nettype none

package stats_pkg;

	// One captured sample, timestamp in the top bits
	typedef struct packed {
		logic [63:0] timestamp;
		logic [63:0] tx_bytes;
		logic [63:0] tx_good;
		logic [63:0] tx_bad;
		logic [63:0] rx_bytes;
		logic [63:0] rx_good;
		logic [63:0] rx_bad;
	} stats_snapshot_t;

	typedef enum logic [1:0] {
		AXI_RESP_OKAY = 2'b00,
		AXI_RESP_SLVERR = 2'b10
	} axi_resp_t;

endpackage

`default_nettype wire

//--- rtl/stats_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_defs.svh"

module stats_regs (
	input wire clk,
	input wire reset,

	input wire write_req,
	input wire [`STATS_ADDR_WIDTH-1:0] write_addr,
	input wire [`STATS_DATA_WIDTH-1:0] write_data,
	input wire [`STATS_DATA_WIDTH/8-1:0] write_strb,
	output logic write_ready,
	output stats_pkg::axi_resp_t write_resp,

	input wire read_req,
	input wire [`STATS_ADDR_WIDTH-1:0] read_addr,
	output logic read_ready,
	output stats_pkg::axi_resp_t read_resp,
	output logic [`STATS_DATA_WIDTH-1:0] read_value,

	input wire stats_pkg::stats_snapshot_t snapshot,
	input wire stats_pkg::stats_snapshot_t head,
	input wire [15:0] occupancy,
	input wire pop_done,

	output logic enable,
	output logic srst,
	output logic hold,
	output logic use_fifo,
	output logic [31:0] interval,
	output logic pop_req
);
	import stats_pkg::*;

	logic [`STATS_ADDR_WIDTH-1:0] wr_word;
	logic [`STATS_ADDR_WIDTH-1:0] rd_word;
	logic [`STATS_DATA_WIDTH-1:0] wr_mask;
	logic wr_accept;
	logic write_ack;
	logic pop_wait;
	logic [6:0][63:0] snap_fields;
	logic [3:0] snap_word;

	assign wr_word = {write_addr[`STATS_ADDR_WIDTH-1:2], 2'b00};
	assign rd_word = {read_addr[`STATS_ADDR_WIDTH-1:2], 2'b00};
	assign wr_mask = {{8{write_strb[3]}}, {8{write_strb[2]}}, {8{write_strb[1]}}, {8{write_strb[0]}}};

	assign wr_accept = write_req & ~write_ack & ~pop_wait;
	// Plain writes finish a cycle after acceptance, pops when the FIFO answers
	assign write_ready = write_ack | pop_done;
	assign write_resp = (write_addr > `STATS_LAST_ADDR) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 1'b0;
			srst <= 1'b0;
			hold <= 1'b0;
			use_fifo <= 1'b0;
			interval <= 32'd0;
			write_ack <= 1'b0;
			pop_req <= 1'b0;
			pop_wait <= 1'b0;
		end else begin
			write_ack <= 1'b0;
			pop_req <= 1'b0;
			if (pop_done) begin
				pop_wait <= 1'b0;
			end
			if (wr_accept) begin
				if (wr_word == `STATS_REG_POP) begin
					pop_req <= 1'b1;
					pop_wait <= 1'b1;
				end else begin
					write_ack <= 1'b1;
				end
				if (wr_word == `STATS_REG_CTRL && write_strb[0]) begin
					enable <= write_data[0];
					srst <= write_data[1];
					hold <= write_data[2];
					use_fifo <= write_data[3];
				end
				if (wr_word == `STATS_REG_INTERVAL) begin
					interval <= (write_data & wr_mask) | (interval & ~wr_mask);
				end
			end
			// Soft reset wins over everything but its own bit
			if (srst) begin
				enable <= 1'b0;
				hold <= 1'b0;
				use_fifo <= 1'b0;
				interval <= 32'd0;
			end
		end
	end

	// Snapshot words run low then high per field, timestamp first
	assign snap_fields = use_fifo ? head : snapshot;
	assign snap_word = 4'(read_addr[6:2] - 5'(`STATS_REG_SNAP >> 2));

	assign read_ready = read_req;

	always_comb begin
		read_resp = AXI_RESP_OKAY;
		read_value = '0;
		if (read_addr > `STATS_LAST_ADDR) begin
			read_resp = AXI_RESP_SLVERR;
		end else if (rd_word >= `STATS_REG_SNAP) begin
			read_value = snap_fields[3'd6 - snap_word[3:1]][{snap_word[0], 5'd0} +: 32];
		end else begin
			case (rd_word)
				`STATS_REG_CTRL: read_value = {28'd0, use_fifo, hold, srst, enable};
				`STATS_REG_OCC: read_value = {16'd0, occupancy};
				`STATS_REG_INTERVAL: read_value = interval;
				default: read_value = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/stats_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module stats_sampler (
	input wire clk,
	input wire reset,
	input wire srst,
	input wire hold,
	input wire use_fifo,
	input wire [31:0] interval,

	input wire [63:0] current_time,
	input wire [5:0] stats_id,
	input wire [63:0] tx_bytes,
	input wire [63:0] tx_good,
	input wire [63:0] tx_bad,
	input wire [63:0] rx_bytes,
	input wire [63:0] rx_good,
	input wire [63:0] rx_bad,

	output stats_pkg::stats_snapshot_t snapshot,
	output logic sample_valid
);
	logic [5:0] last_id;
	logic [31:0] timer;
	logic capture;

	// Hold only freezes the live snapshot, queued mode keeps sampling
	assign capture = (stats_id != last_id) && (timer >= interval) && (use_fifo || !hold);

	always_ff @(posedge clk) begin
		if (reset || srst) begin
			last_id <= 6'd0;
			timer <= 32'd0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= capture;
			if (capture) begin
				last_id <= stats_id;
				timer <= 32'd0;
			end else if (~&timer) begin
				timer <= timer + 32'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || srst) begin
			snapshot <= '0;
		end else if (capture) begin
			snapshot.timestamp <= current_time;
			snapshot.tx_bytes <= tx_bytes;
			snapshot.tx_good <= tx_good;
			snapshot.tx_bad <= tx_bad;
			snapshot.rx_bytes <= rx_bytes;
			snapshot.rx_good <= rx_good;
			snapshot.rx_bad <= rx_bad;
		end
	end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic reset
);
	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- sim/tb_eth_stats_collector_axi.sv
`timescale 1ns/1ps
`default_nettype none

`include "stats_defs.svh"

module tb_eth_stats_collector_axi;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam int HANDSHAKE_LIMIT = 64;
	localparam int CYCLES_PER_ROW = 2000;
	localparam int CAP_NONE = 0;
	localparam int CAP_LIVE = 1;
	localparam int CAP_QUEUE = 2;

	typedef enum {OP_STATS, OP_WRITE, OP_READ, OP_WAIT, OP_SNAP, OP_POP} op_t;
	typedef struct {
		op_t op;
		int test;
		logic [11:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] exp_data;
		logic [1:0] exp_resp;
	} row_t;
	// tx_bytes, tx_good, tx_bad, rx_bytes, rx_good, rx_bad
	typedef logic [5:0][63:0] counters_t;

	logic clk;
	logic reset;
	logic [11:0] awaddr;
	logic [2:0] awprot;
	logic awvalid;
	wire awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	wire wready;
	wire [1:0] bresp;
	wire bvalid;
	logic bready;
	logic [11:0] araddr;
	logic [2:0] arprot;
	logic arvalid;
	wire arready;
	wire [31:0] rdata;
	wire [1:0] rresp;
	wire rvalid;
	logic rready;
	wire enable;
	wire srst;
	logic [63:0] current_time = 64'd0;
	logic [5:0] stats_id;
	counters_t drv;

	row_t rows[$];
	counters_t exp_live;
	counters_t exp_head;
	counters_t fifo_model[$];
	string field_name[7] = '{"time", "tx_bytes", "tx_good", "tx_bad",
		"rx_bytes", "rx_good", "rx_bad"};
	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int cur_test;

	clk_gen u_clk_gen (.clk(clk), .reset(reset));

	eth_stats_collector_axi u_eth_stats_collector_axi (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.enable(enable), .srst(srst),
		.current_time(current_time), .stats_id(stats_id),
		.tx_bytes(drv[0]), .tx_good(drv[1]), .tx_bad(drv[2]),
		.rx_bytes(drv[3]), .rx_good(drv[4]), .rx_bad(drv[5])
	);

	// Free running timestamp
	always @(posedge clk) begin
		if (reset) begin
			current_time <= 64'd0;
		end else begin
			current_time <= current_time + 64'd1;
		end
	end

	task automatic expect_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		test_checks++;
		assert (actual === expected) else begin
			$display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		checks++;
		test_checks++;
		assert (cond) else begin
			$display("Check failed: %s", what);
			errors++;
			test_errors++;
		end
	endtask

	task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int n;
		bit got;
		resp = 2'b00;
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!(awready && wready) && n < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		got = awready && wready;
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		expect_true(got, $sformatf("write to 0x%03h was never accepted", addr));
		n = 0;
		@(negedge clk);
		while (!bvalid && n < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		expect_true(bvalid, $sformatf("write to 0x%03h got no write response", addr));
		resp = bresp;
	endtask

	task automatic bus_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		bit got;
		data = '0;
		resp = 2'b00;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!arready && n < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		got = arready;
		@(posedge clk);
		arvalid <= 1'b0;
		expect_true(got, $sformatf("read of 0x%03h was never accepted", addr));
		n = 0;
		@(negedge clk);
		while (!rvalid && n < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		expect_true(rvalid, $sformatf("read of 0x%03h returned no data", addr));
		data = rdata;
		resp = rresp;
	endtask

	// New ID and counters, then update the expected snapshot by capture kind
	task automatic drive_stats(input logic [5:0] id, input int kind);
		counters_t next;
		int k;
		for (k = 0; k < 6; k++) begin
			next[k] = {$urandom(), $urandom()};
		end
		@(posedge clk);
		stats_id <= id;
		drv <= next;
		repeat (2) @(posedge clk);
		if (kind != CAP_NONE) begin
			exp_live = next;
		end
		if (kind == CAP_QUEUE) begin
			fifo_model.push_back(next);
			if (fifo_model.size() > `STATS_FIFO_DEPTH) begin
				void'(fifo_model.pop_front());
			end
		end
	endtask

	task automatic check_snapshot(input counters_t expected);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [1:0] resp;
		logic [11:0] addr;
		int k;
		bus_read(`STATS_REG_SNAP, lo, resp);
		bus_read(`STATS_REG_SNAP + 12'h4, hi, resp);
		expect_true({hi, lo} != 64'd0,
			$sformatf("snapshot %s reads as zero", field_name[0]));
		for (k = 0; k < 6; k++) begin
			addr = `STATS_REG_SNAP + 12'h8 + 12'(8 * k);
			bus_read(addr, lo, resp);
			expect_word($sformatf("rdata %s lo at 0x%03h", field_name[k + 1], addr),
				expected[k][31:0], lo);
			bus_read(addr + 12'h4, hi, resp);
			expect_word($sformatf("rdata %s hi at 0x%03h", field_name[k + 1], addr + 12'h4),
				expected[k][63:32], hi);
		end
	endtask

	// Empty queue leaves the shown entry in place
	task automatic pop_and_check();
		logic [1:0] resp;
		bus_write(`STATS_REG_POP, 32'h1, 4'hF, resp);
		expect_word("bresp of pop", RESP_OKAY, resp);
		if (fifo_model.size() > 0) begin
			exp_head = fifo_model.pop_front();
		end
		check_snapshot(exp_head);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] data;
		logic [1:0] resp;
		case (r.op)
			OP_STATS: drive_stats(r.data[5:0], r.exp_data);
			OP_WRITE: begin
				bus_write(r.addr, r.data, r.strb, resp);
				expect_word($sformatf("bresp at 0x%03h", r.addr), r.exp_resp, resp);
			end
			OP_READ: begin
				bus_read(r.addr, data, resp);
				expect_word($sformatf("rdata at 0x%03h", r.addr), r.exp_data, data);
				expect_word($sformatf("rresp at 0x%03h", r.addr), r.exp_resp, resp);
				// Control outputs follow the register bits
				if (r.addr == `STATS_REG_CTRL) begin
					expect_word("enable", r.exp_data[0], enable);
					expect_word("srst", r.exp_data[1], srst);
				end
			end
			OP_WAIT: repeat (r.data) @(posedge clk);
			OP_SNAP: check_snapshot(exp_live);
			OP_POP: pop_and_check();
		endcase
	endtask

	task automatic add_row(input op_t op, input int test, input logic [11:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input logic [31:0] exp_data,
			input logic [1:0] exp_resp);
		rows.push_back('{op, test, addr, data, strb, exp_data, exp_resp});
	endtask

	task automatic build_table();
		int k;
		// Control and occupancy after reset and strobe masking
		add_row(OP_READ, 1, `STATS_REG_CTRL, 0, 0, 32'h0, RESP_OKAY);
		add_row(OP_READ, 1, `STATS_REG_OCC, 0, 0, 32'h0, RESP_OKAY);
		add_row(OP_WRITE, 1, `STATS_REG_CTRL, 32'hD, 4'h1, 0, RESP_OKAY);
		add_row(OP_READ, 1, `STATS_REG_CTRL, 0, 0, 32'hD, RESP_OKAY);
		add_row(OP_WRITE, 1, `STATS_REG_CTRL, 32'h0, 4'h0, 0, RESP_OKAY);
		add_row(OP_READ, 1, `STATS_REG_CTRL, 0, 0, 32'hD, RESP_OKAY);
		add_row(OP_WRITE, 1, `STATS_REG_CTRL, 32'h1, 4'hF, 0, RESP_OKAY);
		add_row(OP_READ, 1, `STATS_REG_CTRL, 0, 0, 32'h1, RESP_OKAY);
		// Live capture and an unchanged ID
		add_row(OP_STATS, 2, 0, 1, 0, CAP_LIVE, 0);
		add_row(OP_SNAP, 2, 0, 0, 0, 0, 0);
		add_row(OP_STATS, 2, 0, 1, 0, CAP_NONE, 0);
		add_row(OP_SNAP, 2, 0, 0, 0, 0, 0);
		// Hold and the sample interval
		add_row(OP_WRITE, 3, `STATS_REG_CTRL, 32'h5, 4'hF, 0, RESP_OKAY);
		add_row(OP_STATS, 3, 0, 2, 0, CAP_NONE, 0);
		add_row(OP_SNAP, 3, 0, 0, 0, 0, 0);
		add_row(OP_STATS, 3, 0, 1, 0, CAP_NONE, 0);
		add_row(OP_WRITE, 3, `STATS_REG_CTRL, 32'h1, 4'hF, 0, RESP_OKAY);
		add_row(OP_WRITE, 3, `STATS_REG_INTERVAL, 32'd1000, 4'hF, 0, RESP_OKAY);
		add_row(OP_WAIT, 3, 0, 1100, 0, 0, 0);
		add_row(OP_STATS, 3, 0, 3, 0, CAP_LIVE, 0);
		add_row(OP_SNAP, 3, 0, 0, 0, 0, 0);
		add_row(OP_STATS, 3, 0, 4, 0, CAP_NONE, 0);
		add_row(OP_SNAP, 3, 0, 0, 0, 0, 0);
		add_row(OP_STATS, 3, 0, 3, 0, CAP_NONE, 0);
		add_row(OP_WAIT, 3, 0, 1100, 0, 0, 0);
		add_row(OP_STATS, 3, 0, 5, 0, CAP_LIVE, 0);
		add_row(OP_SNAP, 3, 0, 0, 0, 0, 0);
		add_row(OP_WRITE, 3, `STATS_REG_INTERVAL, 32'd0, 4'hF, 0, RESP_OKAY);
		// FIFO order and pop of an empty queue
		add_row(OP_WRITE, 4, `STATS_REG_CTRL, 32'h9, 4'hF, 0, RESP_OKAY);
		add_row(OP_STATS, 4, 0, 6, 0, CAP_QUEUE, 0);
		add_row(OP_STATS, 4, 0, 7, 0, CAP_QUEUE, 0);
		add_row(OP_STATS, 4, 0, 8, 0, CAP_QUEUE, 0);
		add_row(OP_READ, 4, `STATS_REG_OCC, 0, 0, 32'd3, RESP_OKAY);
		add_row(OP_POP, 4, 0, 0, 0, 0, 0);
		add_row(OP_POP, 4, 0, 0, 0, 0, 0);
		add_row(OP_POP, 4, 0, 0, 0, 0, 0);
		add_row(OP_READ, 4, `STATS_REG_OCC, 0, 0, 32'd0, RESP_OKAY);
		add_row(OP_POP, 4, 0, 0, 0, 0, 0);
		// Overflow drops the oldest
		for (k = 0; k < `STATS_FIFO_DEPTH + 2; k++) begin
			add_row(OP_STATS, 5, 0, 9 + k, 0, CAP_QUEUE, 0);
		end
		add_row(OP_READ, 5, `STATS_REG_OCC, 0, 0, `STATS_FIFO_DEPTH, RESP_OKAY);
		add_row(OP_POP, 5, 0, 0, 0, 0, 0);
		// Out of range access and soft reset
		add_row(OP_READ, 6, 12'h048, 0, 0, 32'h0, RESP_SLVERR);
		add_row(OP_WRITE, 6, 12'h048, 32'hFFFF_FFFF, 4'hF, 0, RESP_SLVERR);
		add_row(OP_WRITE, 6, `STATS_REG_CTRL, 32'hB, 4'h1, 0, RESP_OKAY);
		add_row(OP_READ, 6, `STATS_REG_CTRL, 0, 0, 32'h2, RESP_OKAY);
		add_row(OP_READ, 6, `STATS_REG_OCC, 0, 0, 32'h0, RESP_OKAY);
		add_row(OP_WRITE, 6, `STATS_REG_CTRL, 32'h0, 4'h1, 0, RESP_OKAY);
		add_row(OP_READ, 6, `STATS_REG_CTRL, 0, 0, 32'h0, RESP_OKAY);
	endtask

	task automatic report_test(input int test);
		$display("Test %0d done: %0d checks, %0d errors", test, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: table still running after %0d cycles", cycle_count);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		awaddr = '0;
		awprot = 3'b000;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arprot = 3'b000;
		arvalid = 1'b0;
		rready = 1'b1;
		stats_id = 6'd0;
		drv = '0;
		exp_live = '0;
		exp_head = '0;
		void'($urandom(32'hf850b051));
		build_table();
		cycle_limit = CYCLES_PER_ROW * rows.size();
		do begin
			@(posedge clk);
		end while (reset !== 1'b0);
		cur_test = rows[0].test;
		foreach (rows[i]) begin
			if (rows[i].test != cur_test) begin
				report_test(cur_test);
				cur_test = rows[i].test;
			end
			apply_row(rows[i]);
		end
		report_test(cur_test);
		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
